// File: rtl/cache_geom_pkg.sv
package cache_geom_pkg;

    // two-way write-back data cache, 64 sets
    localparam int SET_BITS = 6;
    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int NUM_WAYS = 2;

    // wide enough for every way of every set dirty at once (0..128)
    localparam int CNT_BITS = $clog2(NUM_SETS * NUM_WAYS + 1);

    // set index into the dirty table
    typedef logic [SET_BITS-1:0] set_idx_t;

    typedef logic [NUM_WAYS-1:0] way_mask_t;   // bit n is way n

    typedef logic [CNT_BITS-1:0] dirty_cnt_t;  // total dirty bits

endpackage

// File: rtl/flush_if_pkg.sv
package flush_if_pkg;

    // pipeline write into the dirty table
    // ways selects which bits change, dirty is the new value
    typedef struct packed {
        cache_geom_pkg::set_idx_t  set;
        cache_geom_pkg::way_mask_t ways;
        logic                      dirty;
    } mark_req_t;

    // writeback request toward memory
    // one per dirty set, ways holds the dirty mask of that set
    typedef struct packed {
        cache_geom_pkg::set_idx_t  set;
        cache_geom_pkg::way_mask_t ways;
    } wb_req_t;

    // apb register map, byte offsets on a 4-bit paddr
    localparam logic [3:0] REG_CTRL    = 4'h0;  // wr bit0 starts a flush
    localparam logic [3:0] REG_STATUS  = 4'h4;  // bit0 busy, 15:8 dirty count
    localparam logic [3:0] REG_FLUSHED = 4'h8;  // requests of the last flush

    // field positions inside the status word
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_CNT_LSB  = 8;

endpackage

// File: rtl/dirty_table.sv
`timescale 1ns/1ps

module dirty_table (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       mark_valid,
    input  logic                       mark_ready,
    input  flush_if_pkg::mark_req_t    mark,
    input  cache_geom_pkg::set_idx_t   lookup_set,
    output cache_geom_pkg::way_mask_t  lookup_dirty,
    input  cache_geom_pkg::set_idx_t   scan_set,
    output cache_geom_pkg::way_mask_t  scan_dirty,
    input  logic                       clear_valid,
    output cache_geom_pkg::dirty_cnt_t dirty_cnt
);
    import cache_geom_pkg::*;

    way_mask_t  dirty_q [NUM_SETS];  // one row per set
    logic       mark_fire;
    set_idx_t   wr_set;
    way_mask_t  old_bits;
    way_mask_t  set_bits;   // bits going 0 -> 1
    way_mask_t  clr_bits;   // bits going 1 -> 0
    logic [1:0] n_set;
    logic [1:0] n_clr;

    assign mark_fire = mark_valid && mark_ready;

    // clear from the flush walk wins over a pipeline mark
    assign wr_set   = clear_valid ? scan_set : mark.set;
    assign old_bits = dirty_q[wr_set];

    always_comb begin
        set_bits = '0;
        clr_bits = '0;
        if (clear_valid) begin
            clr_bits = old_bits;
        end else if (mark_fire) begin
            if (mark.dirty) begin
                set_bits = mark.ways & ~old_bits;  // re-mark of a dirty bit adds nothing
            end else begin
                clr_bits = mark.ways & old_bits;
            end
        end
    end

    assign n_set = {1'b0, set_bits[0]} + {1'b0, set_bits[1]};
    assign n_clr = {1'b0, clr_bits[0]} + {1'b0, clr_bits[1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                dirty_q[i] <= '0;
            end
            dirty_cnt <= '0;
        end else begin
            if (clear_valid || mark_fire) begin
                dirty_q[wr_set] <= (old_bits | set_bits) & ~clr_bits;
            end
            // only real transitions move the count
            dirty_cnt <= dirty_cnt + dirty_cnt_t'(n_set) - dirty_cnt_t'(n_clr);
        end
    end

    assign lookup_dirty = dirty_q[lookup_set];
    assign scan_dirty   = dirty_q[scan_set];  // read port for the flush walk

endmodule

// File: rtl/flush_ctrl.sv
`timescale 1ns/1ps

module flush_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush_start,
    output cache_geom_pkg::set_idx_t   scan_set,
    input  cache_geom_pkg::way_mask_t  scan_dirty,
    input  cache_geom_pkg::dirty_cnt_t dirty_cnt,
    output logic                       clear_valid,
    output logic                       push,
    output flush_if_pkg::wb_req_t      push_req,
    input  logic                       queue_full,
    output logic                       mark_ready,
    output logic                       busy,
    output logic                       flush_done,
    output cache_geom_pkg::dirty_cnt_t flushed_cnt
);
    import cache_geom_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SEARCH = 2'b01,
        ISSUE  = 2'b10,
        DONE   = 2'b11
    } state_t;

    state_t     state_q;
    state_t     state_d;
    set_idx_t   ptr_q;       // set under inspection
    logic [1:0] scan_bits;   // dirty bits in the current set
    dirty_cnt_t remain;      // count left once this set is cleared
    logic       last_set;
    logic       clean_step;  // search moves past a clean set

    assign scan_set  = ptr_q;
    assign scan_bits = {1'b0, scan_dirty[0]} + {1'b0, scan_dirty[1]};
    assign remain    = dirty_cnt - dirty_cnt_t'(scan_bits);
    assign last_set  = (ptr_q == set_idx_t'(NUM_SETS - 1));

    assign clean_step = (state_q == SEARCH) && (scan_dirty == '0) && !last_set;

    always_comb begin
        state_d = state_q;
        push    = 1'b0;
        case (state_q)
            IDLE: begin
                if (flush_start) begin
                    state_d = SEARCH;
                end
            end
            SEARCH: begin
                if (scan_dirty != '0) begin
                    state_d = ISSUE;
                end else if (last_set || dirty_cnt == '0) begin
                    state_d = DONE;  // nothing left, or walked off the end
                end
            end
            ISSUE: begin
                push = !queue_full;  // hold here while memory stalls
                if (push) begin
                    state_d = (last_set || remain == '0) ? DONE : SEARCH;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // set is zeroed on the same edge its request enters the queue
    assign clear_valid = push;
    assign push_req    = '{set: ptr_q, ways: scan_dirty};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q     <= IDLE;
            ptr_q       <= '0;
            flushed_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && flush_start) begin
                ptr_q       <= '0;
                flushed_cnt <= '0;
            end else if (push) begin
                ptr_q       <= ptr_q + 1'b1;
                flushed_cnt <= flushed_cnt + 1'b1;
            end else if (clean_step) begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    assign busy       = (state_q != IDLE);
    assign mark_ready = !busy;       // table is frozen for the walk
    assign flush_done = (state_q == DONE);

endmodule

// File: rtl/wb_queue.sv
`timescale 1ns/1ps

module wb_queue #(
    parameter int WB_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  push,
    input  flush_if_pkg::wb_req_t push_req,
    output logic                  queue_full,
    output logic                  wb_valid,
    output flush_if_pkg::wb_req_t wb_req,
    input  logic                  wb_ready
);
    import flush_if_pkg::*;

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
    localparam int CNT_W = $clog2(WB_DEPTH + 1);

    wb_req_t          mem [WB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;   // entries held
    logic             push_ok;
    logic             pop;

    assign queue_full = (count_q == CNT_W'(WB_DEPTH));
    assign wb_valid   = (count_q != '0);
    assign wb_req     = mem[rd_ptr];  // head stays put until the transfer

    assign push_ok = push && !queue_full;
    assign pop     = wb_valid && wb_ready;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

endmodule

// File: rtl/apb_flush_regs.sv
`timescale 1ns/1ps

module apb_flush_regs (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [3:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       busy,
    input  logic                       flush_done,
    input  cache_geom_pkg::dirty_cnt_t dirty_cnt,
    input  cache_geom_pkg::dirty_cnt_t flushed_cnt,
    output logic                       flush_start
);
    import cache_geom_pkg::*;
    import flush_if_pkg::*;

    dirty_cnt_t  flushed_q;  // REG_FLUSHED contents
    logic        access;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_flushed;
    logic [31:0] status_word;

    // access phase, always one cycle since pready is tied high
    assign access = psel && penable;

    assign hit_ctrl    = (paddr == REG_CTRL);
    assign hit_status  = (paddr == REG_STATUS);
    assign hit_flushed = (paddr == REG_FLUSHED);

    assign pready  = 1'b1;
    assign pslverr = access && !(hit_ctrl || hit_status || hit_flushed);

    // a start written while a flush runs is dropped
    assign flush_start = access && pwrite && hit_ctrl && pwdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flushed_q <= '0;
        end else if (flush_done) begin
            flushed_q <= flushed_cnt;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_BUSY_BIT] = busy;
        status_word[STATUS_CNT_LSB +: CNT_BITS] = dirty_cnt;
    end

    always_comb begin
        prdata = '0;  // CTRL reads back as zero
        if (hit_status) begin
            prdata = status_word;
        end else if (hit_flushed) begin
            prdata = 32'(flushed_q);
        end
    end

endmodule

// File: rtl/dcache_flush_top.sv
`timescale 1ns/1ps

module dcache_flush_top #(
    parameter int WB_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      mark_valid,
    input  flush_if_pkg::mark_req_t   mark,
    output logic                      mark_ready,
    input  cache_geom_pkg::set_idx_t  lookup_set,
    output cache_geom_pkg::way_mask_t lookup_dirty,
    output logic                      wb_valid,
    output flush_if_pkg::wb_req_t     wb_req,
    input  logic                      wb_ready,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [3:0]                paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      flush_done
);
    import cache_geom_pkg::*;
    import flush_if_pkg::*;

    set_idx_t   scan_set;
    way_mask_t  scan_dirty;
    dirty_cnt_t dirty_cnt;
    dirty_cnt_t flushed_cnt;
    wb_req_t    push_req;
    logic       flush_start;
    logic       clear_valid;
    logic       push;
    logic       queue_full;
    logic       busy;

    dirty_table u_table (
        .clk, .rstn,
        .mark_valid, .mark_ready, .mark,
        .lookup_set, .lookup_dirty,
        .scan_set, .scan_dirty, .clear_valid,
        .dirty_cnt
    );

    flush_ctrl u_ctrl (
        .clk, .rstn,
        .flush_start,
        .scan_set, .scan_dirty, .dirty_cnt, .clear_valid,
        .push, .push_req, .queue_full,
        .mark_ready, .busy, .flush_done, .flushed_cnt
    );

    wb_queue #(.WB_DEPTH(WB_DEPTH)) u_queue (
        .clk, .rstn,
        .push, .push_req, .queue_full,
        .wb_valid, .wb_req, .wb_ready
    );

    apb_flush_regs u_regs (
        .clk, .rstn,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .flush_done, .dirty_cnt, .flushed_cnt,
        .flush_start
    );

endmodule

// File: verification/flush_props.sv
`timescale 1ns/1ps

module flush_props (
    input logic                       clk,
    input logic                       rstn,
    input logic                       queue_full,
    input logic                       clear_valid,
    input logic                       busy,
    input logic                       flush_done,
    input cache_geom_pkg::set_idx_t   scan_set,
    input cache_geom_pkg::way_mask_t  scan_dirty,
    input cache_geom_pkg::dirty_cnt_t dirty_cnt
);

    // a stalled request keeps its set until the queue takes it
    a_stall_holds_set: assert property (
        @(posedge clk) disable iff (!rstn)
            busy && queue_full && (scan_dirty != '0) |=> $stable(scan_set)
    ) else $error("scan moved off a dirty set while the queue was full");

    // only dirty sets get written back and zeroed
    a_clear_drops_count: assert property (
        @(posedge clk) disable iff (!rstn) clear_valid |=> dirty_cnt < $past(dirty_cnt)
    ) else $error("set cleared without lowering the dirty count");

    a_marks_blocked: assert property (
        @(posedge clk) disable iff (!rstn) busy |=> dirty_cnt <= $past(dirty_cnt)
    ) else $error("dirty count rose during a flush");

    // nothing left dirty once the walk ends
    a_done_clean: assert property (
        @(posedge clk) disable iff (!rstn) flush_done |-> dirty_cnt == '0
    ) else $error("flush finished with dirty lines left");

endmodule

bind flush_ctrl flush_props u_props (
    .clk         (clk),
    .rstn        (rstn),
    .queue_full  (queue_full),
    .clear_valid (clear_valid),
    .busy        (busy),
    .flush_done  (flush_done),
    .scan_set    (scan_set),
    .scan_dirty  (scan_dirty),
    .dirty_cnt   (dirty_cnt)
);

// File: verification/tb_flush_top.sv
`timescale 1ns/1ps

module tb_flush_top;
    import cache_geom_pkg::*;
    import flush_if_pkg::*;

    localparam int WB_DEPTH      = 4;
    localparam int FLUSH_TIMEOUT = 2000;  // cycles for walk plus drain

    typedef struct packed {
        mark_req_t req;
        way_mask_t exp;  // lookup mask right after the mark
    } row_t;

    logic        clk;
    logic        rstn;
    logic        mark_valid;
    mark_req_t   mark;
    logic        mark_ready;
    set_idx_t    lookup_set;
    way_mask_t   lookup_dirty;
    logic        wb_valid;
    wb_req_t     wb_req;
    logic        wb_ready;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        flush_done;

    row_t        rows[$];
    string       row_names[$];
    way_mask_t   model[NUM_SETS];  // reference dirty table
    wb_req_t     exp_reqs[$];
    wb_req_t     got_reqs[$];
    logic [31:0] rng;
    string       cur_test;
    int          errors;
    int          test_errs;
    int          tests;
    int          failed_tests;

    dcache_flush_top #(.WB_DEPTH(WB_DEPTH)) dut (
        .clk, .rstn,
        .mark_valid, .mark, .mark_ready,
        .lookup_set, .lookup_dirty,
        .wb_valid, .wb_req, .wb_ready,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .flush_done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic dirty_cnt_t model_count();
        int n;
        n = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            n += $countones(model[s]);
        end
        return dirty_cnt_t'(n);
    endfunction

    // busy sits in bit 0 and the count in 15:8
    function automatic logic [31:0] expected_status(input logic busy, input dirty_cnt_t cnt);
        logic [31:0] w;
        w       = '0;
        w[0]    = busy;
        w[15:8] = cnt;
        return w;
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errs) begin
            $display("ok      %s", cur_test);
        end else begin
            failed_tests++;
            $display("failed  %s (%0d errors)", cur_test, errors - test_errs);
        end
    endtask

    task automatic check_mask(input string what, input way_mask_t exp, input way_mask_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic check_cnt(input string what, input dirty_cnt_t exp, input dirty_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_req(input string what, input wb_req_t exp, input wb_req_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected set %0d ways %b, actual set %0d ways %b",
                     what, exp.set, exp.ways, act.set, act.ways);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_bit($sformatf("%s pready", cur_test), 1'b1, pready);
        @(posedge clk);  // write lands on this access edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_bit($sformatf("%s pready", cur_test), 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apply_mark(input mark_req_t req, output way_mask_t seen);
        @(posedge clk);
        mark_valid <= 1'b1;
        mark       <= req;
        lookup_set <= req.set;
        @(posedge clk);  // accepted on this edge
        mark_valid <= 1'b0;
        @(negedge clk);
        seen = lookup_dirty;
    endtask

    task automatic read_lookup(input set_idx_t s, output way_mask_t seen);
        @(posedge clk);
        lookup_set <= s;
        @(negedge clk);
        seen = lookup_dirty;
    endtask

    task automatic add_row(input string name, input set_idx_t s, input way_mask_t w,
                           input logic d, input way_mask_t exp);
        row_t r;
        r.req = '{set: s, ways: w, dirty: d};
        r.exp = exp;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    initial begin
        mark_req_t   blocked;
        wb_req_t     req_exp;
        way_mask_t   seen;
        logic [31:0] rd;
        logic        err;
        logic        ready_in_flush;
        logic        done;
        int          cyc;
        int          done_pulses;

        rstn       = 1'b0;
        mark_valid = 1'b0;
        mark       = '0;
        lookup_set = '0;
        wb_ready   = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rng          = 32'he99d;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model[s] = '0;
        end
        // set 0 is already written back when this arrives
        blocked = '{set: 6'd0, ways: 2'b11, dirty: 1'b1};

        add_row("set0_way0",        6'd0,  2'b01, 1'b1, 2'b01);
        add_row("set0_way1",        6'd0,  2'b10, 1'b1, 2'b11);
        add_row("set5_both",        6'd5,  2'b11, 1'b1, 2'b11);
        add_row("set5_remark",      6'd5,  2'b01, 1'b1, 2'b11);
        add_row("set5_clean_way0",  6'd5,  2'b01, 1'b0, 2'b10);
        add_row("set9_clean_noop",  6'd9,  2'b01, 1'b0, 2'b00);
        add_row("set20_way1",       6'd20, 2'b10, 1'b1, 2'b10);
        add_row("set33_both",       6'd33, 2'b11, 1'b1, 2'b11);
        add_row("set33_clean_both", 6'd33, 2'b11, 1'b0, 2'b00);
        add_row("set40_way0",       6'd40, 2'b01, 1'b1, 2'b01);
        add_row("set63_both",       6'd63, 2'b11, 1'b1, 2'b11);

        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        start_test("reset_state");
        apb_read(REG_STATUS, rd, err);
        check_word(cur_test, expected_status(1'b0, '0), rd);
        @(negedge clk);
        check_bit(cur_test, 1'b1, mark_ready);
        check_bit(cur_test, 1'b0, wb_valid);
        check_bit(cur_test, 1'b0, flush_done);
        end_test();

        foreach (rows[i]) begin
            start_test(row_names[i]);
            apply_mark(rows[i].req, seen);
            if (rows[i].req.dirty) begin
                model[rows[i].req.set] = model[rows[i].req.set] | rows[i].req.ways;
            end else begin
                model[rows[i].req.set] = model[rows[i].req.set] & ~rows[i].req.ways;
            end
            if (model[rows[i].req.set] !== rows[i].exp) begin
                errors++;
                $display("table row %s disagrees with the reference model", row_names[i]);
            end
            check_mask(cur_test, model[rows[i].req.set], seen);
            end_test();
        end

        start_test("table_count");
        apb_read(REG_STATUS, rd, err);
        check_cnt(cur_test, model_count(), rd[15:8]);
        check_bit(cur_test, 1'b0, rd[0]);
        end_test();

        // one request per dirty set in ascending order
        exp_reqs = {};
        for (int s = 0; s < NUM_SETS; s++) begin
            if (model[s] != '0) begin
                req_exp = '{set: set_idx_t'(s), ways: model[s]};
                exp_reqs.push_back(req_exp);
            end
        end

        start_test("flush_requests");
        apb_write(REG_CTRL, 32'h1, err);
        check_bit(cur_test, 1'b0, err);
        got_reqs       = {};
        ready_in_flush = 1'b0;
        done           = 1'b0;
        cyc            = 0;
        done_pulses    = 0;
        while (!done && cyc < FLUSH_TIMEOUT) begin
            @(posedge clk);
            rng = xorshift(rng);
            wb_ready   <= rng[0];  // random memory stalls
            mark_valid <= (cyc >= 1 && cyc <= 3);
            mark       <= blocked;
            @(negedge clk);
            if (mark_valid) begin
                ready_in_flush |= mark_ready;
            end
            if (flush_done) begin
                done_pulses++;
            end
            if (wb_valid && wb_ready) begin
                got_reqs.push_back(wb_req);
            end
            done = mark_ready && !wb_valid;  // idle and queue drained
            cyc++;
        end
        if (!done) begin
            errors++;
            $display("flush did not finish and drain within %0d cycles", FLUSH_TIMEOUT);
        end
        check_cnt(cur_test, dirty_cnt_t'(exp_reqs.size()), dirty_cnt_t'(got_reqs.size()));
        for (int i = 0; i < exp_reqs.size() && i < got_reqs.size(); i++) begin
            check_req($sformatf("%s #%0d", cur_test, i), exp_reqs[i], got_reqs[i]);
        end
        check_word($sformatf("%s flush_done pulses", cur_test), 32'd1, 32'(done_pulses));
        end_test();
        for (int s = 0; s < NUM_SETS; s++) begin
            model[s] = '0;
        end

        start_test("blocked_mark");
        check_bit(cur_test, 1'b0, ready_in_flush);
        read_lookup(blocked.set, seen);
        check_mask(cur_test, model[blocked.set], seen);
        end_test();

        start_test("post_flush_status");
        apb_read(REG_STATUS, rd, err);
        check_word(cur_test, expected_status(1'b0, model_count()), rd);
        end_test();

        start_test("post_flush_lookups");
        for (int s = 0; s < NUM_SETS; s++) begin
            read_lookup(set_idx_t'(s), seen);
            check_mask($sformatf("%s set %0d", cur_test, s), model[s], seen);
        end
        end_test();

        start_test("flushed_reg");
        apb_read(REG_FLUSHED, rd, err);
        check_word(cur_test, 32'(exp_reqs.size()), rd);
        end_test();

        start_test("bad_offset");
        apb_read(4'hC, rd, err);
        check_bit(cur_test, 1'b1, err);
        end_test();

        start_test("good_offset");
        apb_read(REG_STATUS, rd, err);
        check_bit(cur_test, 1'b0, err);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/cache_geom_pkg.sv
rtl/flush_if_pkg.sv
rtl/dirty_table.sv
rtl/flush_ctrl.sv
rtl/wb_queue.sv
rtl/apb_flush_regs.sv
rtl/dcache_flush_top.sv
verification/flush_props.sv
verification/tb_flush_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_flush_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
